/* hdl/set2_set1_table.svh */
/*
 * Scan code set 2 to set 1 table
 * Entry n holds the set 1 code for set 2 code n, for codes 0x00
 * through TABLE_LAST. Codes above that map to themselves
 */
`ifndef SET2_SET1_TABLE_SVH
`define SET2_SET1_TABLE_SVH

// Highest set 2 code with its own table entry
localparam logic [7:0] TABLE_LAST = 8'h84;

localparam logic [7:0] SET2_TO_SET1 [0:132] = '{
	8'hff, 8'h43, 8'h41, 8'h3f, 8'h3d, 8'h3b, 8'h3c, 8'h58,   // 0x00
	8'h64, 8'h44, 8'h42, 8'h40, 8'h3e, 8'h0f, 8'h29, 8'h59,   // 0x08
	8'h65, 8'h38, 8'h2a, 8'h70, 8'h1d, 8'h10, 8'h02, 8'h5a,   // 0x10
	8'h66, 8'h71, 8'h2c, 8'h1f, 8'h1e, 8'h11, 8'h03, 8'h5b,   // 0x18
	8'h67, 8'h2e, 8'h2d, 8'h20, 8'h12, 8'h05, 8'h04, 8'h5c,   // 0x20
	8'h68, 8'h39, 8'h2f, 8'h21, 8'h14, 8'h13, 8'h06, 8'h5d,   // 0x28
	8'h69, 8'h31, 8'h30, 8'h23, 8'h22, 8'h15, 8'h07, 8'h5e,   // 0x30
	8'h6a, 8'h72, 8'h32, 8'h24, 8'h16, 8'h08, 8'h09, 8'h5f,   // 0x38
	8'h6b, 8'h33, 8'h25, 8'h17, 8'h18, 8'h0b, 8'h0a, 8'h60,   // 0x40
	8'h6c, 8'h34, 8'h35, 8'h26, 8'h27, 8'h19, 8'h0c, 8'h61,   // 0x48
	8'h6d, 8'h73, 8'h28, 8'h74, 8'h1a, 8'h0d, 8'h62, 8'h6e,   // 0x50
	8'h3a, 8'h36, 8'h1c, 8'h1b, 8'h75, 8'h2b, 8'h63, 8'h76,   // 0x58
	8'h55, 8'h56, 8'h77, 8'h78, 8'h79, 8'h7a, 8'h0e, 8'h7b,   // 0x60
	8'h7c, 8'h4f, 8'h7d, 8'h4b, 8'h47, 8'h7e, 8'h7f, 8'h6f,   // 0x68
	8'h52, 8'h53, 8'h50, 8'h4c, 8'h4d, 8'h48, 8'h01, 8'h45,   // 0x70
	8'h57, 8'h4e, 8'h51, 8'h4a, 8'h37, 8'h49, 8'h46, 8'h54,   // 0x78
	// F7 and alternate F7/SysRq codes
	8'h80, 8'h81, 8'h82, 8'h41, 8'h54                         // 0x80
};

`endif

/* hdl/kbd_pkg.sv */
/*
 * Keyboard translator package
 * Shared frame and status structs plus default sizing for the
 * PS/2 to PC/XT keyboard bridge
 */
package kbd_pkg;

	// One received PS/2 frame, data bits in order
	typedef struct packed {
		logic [7:0] code;
		logic       parity_ok;  // Odd parity matched
	} ps2_byte_t;

	// Top-level status
	typedef struct packed {
		logic parity_error;     // One-cycle strobe per bad frame
		logic overflow;         // Sticky until reset
	} xlate_status_t;

	// System clock cycles per XT half-bit
	parameter int DEF_BIT_CYCLES = 16;

	// Translated byte queue depth, power of two
	parameter int DEF_FIFO_DEPTH = 8;

	// Set 2 break prefix
	parameter logic [7:0] BREAK_PREFIX = 8'hF0;

endpackage

/* hdl/ps2_rx.sv */
`timescale 1ns/1ps
/*
 * PS/2 receiver
 * Samples the keyboard clock and data on the system clock, shifts in
 * 11-bit frames on falling keyboard clock edges and strobes out each
 * byte together with its odd parity check
 */
module ps2_rx import kbd_pkg::*; (
	input  logic      latch,
	input  logic      reset,
	input  logic      ps2_clk,
	input  logic      ps2_data,
	output logic      rx_valid,
	output ps2_byte_t rx_byte
);

	logic [1:0]  clk_sync;     // Two-stage synchronizers
	logic [1:0]  data_sync;
	logic        clk_prev;
	logic        clk_fall;
	logic [3:0]  bit_cnt;      // Bits taken so far in this frame
	logic [9:0]  shift_reg;
	logic [10:0] frame;
	logic        frame_done;

	// Lines idle high, so sync stages come out of reset high
	always_ff @(posedge latch) begin
		if (reset) begin
			clk_sync  <= 2'b11;
			data_sync <= 2'b11;
			clk_prev  <= 1'b1;
		end else begin
			clk_sync  <= {clk_sync[0], ps2_clk};
			data_sync <= {data_sync[0], ps2_data};
			clk_prev  <= clk_sync[1];
		end
	end

	assign clk_fall = clk_prev & ~clk_sync[1];

	// Bit arriving now sits on top of the first ten
	assign frame      = {data_sync[1], shift_reg};
	assign frame_done = clk_fall && (bit_cnt == 4'd10);   // Stop bit edge

	always_ff @(posedge latch) begin
		if (reset) begin
			bit_cnt <= '0;
		end else if (frame_done) begin
			bit_cnt <= '0;
		end else if (clk_fall) begin
			bit_cnt <= bit_cnt + 4'd1;
		end
	end

	// LSB first, so shift right
	always_ff @(posedge latch) begin
		if (clk_fall) begin
			shift_reg <= frame[10:1];
		end
	end

	// Frame with a high start bit is dropped
	always_ff @(posedge latch) begin
		if (reset) begin
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= frame_done && !frame[0];
		end
	end

	always_ff @(posedge latch) begin
		if (frame_done) begin
			rx_byte.code      <= frame[8:1];
			rx_byte.parity_ok <= ^frame[9:1];   // Odd count of ones
		end
	end

endmodule

/* hdl/scan_xlate.sv */
`timescale 1ns/1ps
/*
 * Scan code translator
 * Maps each good set 2 byte to set 1, folds a preceding break prefix
 * into bit 7 and flags frames that failed the parity check
 */
module scan_xlate import kbd_pkg::*; (
	input  logic       latch,
	input  logic       reset,
	input  logic       rx_valid,
	input  ps2_byte_t  rx_byte,
	output logic       xl_valid,
	output logic [7:0] xl_code,
	output logic       parity_error
);

	`include "set2_set1_table.svh"

	logic       break_flag;   // Last good byte was the break prefix
	logic [7:0] set1_code;

	function automatic logic [7:0] lookup(input logic [7:0] code);
		logic [7:0] result;
		if (code <= TABLE_LAST) begin
			result = SET2_TO_SET1[code];
		end else begin
			result = code;   // High codes pass through
		end
		return result;
	endfunction

	assign set1_code = lookup(rx_byte.code);

	always_ff @(posedge latch) begin
		if (reset) begin
			xl_valid     <= 1'b0;
			parity_error <= 1'b0;
			break_flag   <= 1'b0;
		end else begin
			xl_valid     <= 1'b0;
			parity_error <= 1'b0;
			if (rx_valid) begin
				if (!rx_byte.parity_ok) begin
					parity_error <= 1'b1;   // Dropped, break state kept
				end else if (rx_byte.code == BREAK_PREFIX) begin
					break_flag <= 1'b1;
				end else begin
					xl_valid   <= 1'b1;
					break_flag <= 1'b0;
				end
			end
		end
	end

	// Break turns into the set 1 release bit
	always_ff @(posedge latch) begin
		if (rx_valid) begin
			xl_code <= set1_code | {break_flag, 7'b0};
		end
	end

endmodule

/* hdl/scan_fifo.sv */
`timescale 1ns/1ps
/*
 * Translated byte queue
 * Circular buffer between translator and XT transmitter. The head byte
 * is shown without a read cycle; writes into a full queue are lost and
 * raise a sticky overflow flag
 */
module scan_fifo import kbd_pkg::*; #(
	parameter int FIFO_DEPTH = DEF_FIFO_DEPTH
) (
	input  logic       latch,
	input  logic       reset,
	input  logic       wr,
	input  logic [7:0] wr_code,
	input  logic       pop,
	output logic [7:0] head,
	output logic       empty,
	output logic       overflow
);

	localparam int AW = $clog2(FIFO_DEPTH);

	logic [7:0]  mem [FIFO_DEPTH];
	logic [AW:0] wr_ptr;   // Extra bit tells full from empty
	logic [AW:0] rd_ptr;
	logic        full;

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
	assign head  = mem[rd_ptr[AW-1:0]];

	always_ff @(posedge latch) begin
		if (wr && !full) begin
			mem[wr_ptr[AW-1:0]] <= wr_code;
		end
	end

	always_ff @(posedge latch) begin
		if (reset) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			overflow <= 1'b0;
		end else begin
			if (wr) begin
				if (full) begin
					overflow <= 1'b1;
				end else begin
					wr_ptr <= wr_ptr + 1'b1;
				end
			end
			if (pop && !empty) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

endmodule

/* hdl/xt_tx.sv */
`timescale 1ns/1ps
/*
 * PC/XT keyboard transmitter
 * Pops one byte at a time and clocks it to the PC as a start bit of one
 * followed by eight data bits LSB first, then waits out the idle gap
 */
module xt_tx import kbd_pkg::*; #(
	parameter int BIT_CYCLES = DEF_BIT_CYCLES
) (
	input  logic       latch,
	input  logic       reset,
	input  logic       empty,
	input  logic [7:0] head,
	output logic       pop,
	output logic       pc_clk,
	output logic       pc_data
);

	localparam int CW = $clog2(2 * BIT_CYCLES);

	typedef enum logic [1:0] {
		IDLE,
		CLK_LOW,
		CLK_HIGH
	} tx_state_t;

	tx_state_t     state;
	logic [CW-1:0] half_cnt;    // Cycles left in this half or gap
	logic [3:0]    bit_cnt;     // Bits finished
	logic [8:0]    shift_reg;   // Bit 0 drives the data line

	assign pop     = (state == IDLE) && (half_cnt == '0) && !empty;
	assign pc_data = shift_reg[0];

	always_ff @(posedge latch) begin
		if (reset) begin
			state     <= IDLE;
			half_cnt  <= '0;
			bit_cnt   <= '0;
			shift_reg <= '1;
			pc_clk    <= 1'b1;
		end else begin
			case (state)
				IDLE: begin
					if (half_cnt != '0) begin
						half_cnt <= half_cnt - CW'(1);
					end else if (!empty) begin
						// Start bit equals the idle level, so it is already set up
						shift_reg <= {head, 1'b1};
						bit_cnt   <= '0;
						half_cnt  <= CW'(BIT_CYCLES - 1);
						pc_clk    <= 1'b0;
						state     <= CLK_LOW;
					end
				end
				CLK_LOW: begin
					if (half_cnt != '0) begin
						half_cnt <= half_cnt - CW'(1);
					end else begin
						shift_reg <= {1'b1, shift_reg[8:1]};   // Next bit on rising clock
						bit_cnt   <= bit_cnt + 4'd1;
						half_cnt  <= CW'(BIT_CYCLES - 1);
						pc_clk    <= 1'b1;
						state     <= CLK_HIGH;
					end
				end
				CLK_HIGH: begin
					if (half_cnt != '0) begin
						half_cnt <= half_cnt - CW'(1);
					end else if (bit_cnt == 4'd9) begin
						half_cnt <= CW'(2 * BIT_CYCLES - 1);   // Gap before next pop
						state    <= IDLE;
					end else begin
						half_cnt <= CW'(BIT_CYCLES - 1);
						pc_clk   <= 1'b0;
						state    <= CLK_LOW;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

/* hdl/kbd_xlate_top.sv */
`timescale 1ns/1ps
/*
 * PS/2 to PC/XT keyboard bridge
 * Receiver, set 2 to set 1 translator, byte queue and XT transmitter
 */
module kbd_xlate_top import kbd_pkg::*; #(
	parameter int BIT_CYCLES = DEF_BIT_CYCLES,
	parameter int FIFO_DEPTH = DEF_FIFO_DEPTH
) (
	input  logic          latch,
	input  logic          reset,
	input  logic          ps2_clk,
	input  logic          ps2_data,
	output logic          pc_clk,
	output logic          pc_data,
	output xlate_status_t status
);

	logic       rx_valid;
	ps2_byte_t  rx_byte;
	logic       xl_valid;
	logic [7:0] xl_code;
	logic       parity_error;
	logic       pop;
	logic       empty;
	logic       overflow;
	logic [7:0] head;   // Oldest queued set 1 byte

	ps2_rx rx_i (
		.latch    (latch),
		.reset    (reset),
		.ps2_clk  (ps2_clk),
		.ps2_data (ps2_data),
		.rx_valid (rx_valid),
		.rx_byte  (rx_byte)
	);

	scan_xlate xlate_i (
		.latch        (latch),
		.reset        (reset),
		.rx_valid     (rx_valid),
		.rx_byte      (rx_byte),
		.xl_valid     (xl_valid),
		.xl_code      (xl_code),
		.parity_error (parity_error)
	);

	scan_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_i (
		.latch    (latch),
		.reset    (reset),
		.wr       (xl_valid),
		.wr_code  (xl_code),
		.pop      (pop),
		.head     (head),
		.empty    (empty),
		.overflow (overflow)
	);

	xt_tx #(.BIT_CYCLES(BIT_CYCLES)) tx_i (
		.latch   (latch),
		.reset   (reset),
		.empty   (empty),
		.head    (head),
		.pop     (pop),
		.pc_clk  (pc_clk),
		.pc_data (pc_data)
	);

	assign status.parity_error = parity_error;
	assign status.overflow     = overflow;

endmodule

/* dv/kbd_xlate_tb.sv */
`timescale 1ns/1ps
/*
 * Testbench for the PS/2 to PC/XT keyboard bridge
 * Plays a PS/2 keyboard and an XT host around the DUT and checks
 * translation, break prefix, parity errors and queue overflow
 */
module kbd_xlate_tb import kbd_pkg::*; ();

	localparam int BIT_CYCLES    = 4;
	localparam int FIFO_DEPTH    = 4;
	localparam int PS2_HALF      = 6;    // Keyboard half-period in latch cycles
	localparam int FAST_HALF     = 2;    // Burst half-period above the sync delay
	localparam int WAIT_LIMIT    = 400;  // Cycles before a single wait gives up
	localparam int PS2_FRAME_CYC = 22 * FAST_HALF;
	localparam int XT_BYTE_CYC   = 20 * BIT_CYCLES;   // Nine bits plus the idle gap
	// Fast frames outrun the XT side, so this many must fill the queue
	localparam int BURST = (FIFO_DEPTH + 2) * XT_BYTE_CYC / (XT_BYTE_CYC - PS2_FRAME_CYC) + 2;

	logic          latch;
	logic          reset;
	logic          ps2_clk;
	logic          ps2_data;
	logic          pc_clk;
	logic          pc_data;
	xlate_status_t status;

	int     value_errors = 0;
	int     other_errors = 0;
	integer seed = 32'h1d46;

	// Set 2 make codes and their set 1 values
	logic [7:0] known_set2 [6] = '{8'h1C, 8'h16, 8'h5A, 8'h83, 8'h84, 8'h00};
	logic [7:0] known_set1 [6] = '{8'h1E, 8'h02, 8'h1C, 8'h41, 8'h54, 8'hFF};

	kbd_xlate_top #(
		.BIT_CYCLES (BIT_CYCLES),
		.FIFO_DEPTH (FIFO_DEPTH)
	) dut_i (
		.latch    (latch),
		.reset    (reset),
		.ps2_clk  (ps2_clk),
		.ps2_data (ps2_data),
		.pc_clk   (pc_clk),
		.pc_data  (pc_data),
		.status   (status)
	);

	always #4 latch = ~latch;

	task automatic check_code(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s: expected 0x%02h, got 0x%02h", name, exp, got);
			value_errors++;
		end
	endtask

	task automatic check_status(input string name, input xlate_status_t got,
			input xlate_status_t exp);
		if (got !== exp) begin
			$display("[ERROR] %s: expected 0x%01h, got 0x%01h", name, exp, got);
			value_errors++;
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] %s: expected 0x%01h, got 0x%01h", name, exp, got);
			value_errors++;
		end
	endtask

	// Keyboard model that moves data while the clock is high
	task automatic send_ps2(input logic [7:0] code, input int half, input bit bad_parity);
		logic [10:0] frame;
		frame = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
		for (int i = 0; i < 11; i++) begin
			ps2_data = frame[i];
			repeat (half) @(negedge latch);
			ps2_clk = 1'b0;
			repeat (half) @(negedge latch);
			ps2_clk = 1'b1;
		end
	endtask

	task automatic wait_pc_clk(input logic level, output bit ok);
		int t;
		t = 0;
		while (pc_clk !== level && t < WAIT_LIMIT) begin
			@(negedge latch);
			t++;
		end
		ok = (pc_clk === level);
		if (!ok) begin
			$display("Timed out after %0d cycles waiting for pc_clk to go %s",
				WAIT_LIMIT, level ? "high" : "low");
			other_errors++;
		end
	endtask

	// PC model taking one bit per falling pc_clk
	task automatic recv_xt(output logic [7:0] code, output bit ok);
		logic [8:0] frame;
		frame = '1;
		ok    = 1'b1;
		for (int i = 0; i < 9 && ok; i++) begin
			wait_pc_clk(1'b1, ok);
			if (ok) begin
				wait_pc_clk(1'b0, ok);
			end
			frame[i] = pc_data;
		end
		if (ok) begin
			check_level("pc_data start bit", frame[0], 1'b1);
		end
		code = frame[8:1];
	endtask

	task automatic expect_xt(input logic [7:0] exp);
		logic [7:0] got;
		bit         ok;
		recv_xt(got, ok);
		if (ok) begin
			check_code("pc_data byte", got, exp);
		end
	endtask

	task automatic translate_one(input logic [7:0] set2, input logic [7:0] set1);
		fork
			send_ps2(set2, PS2_HALF, 1'b0);
			expect_xt(set1);
		join
	endtask

	task automatic expect_quiet(input int cycles);
		bit busy;
		busy = 1'b0;
		repeat (cycles) begin
			@(negedge latch);
			if (pc_clk == 1'b0) begin
				busy = 1'b1;
			end
		end
		if (busy) begin
			$display("A byte reached the PC although none was expected");
			other_errors++;
		end
	endtask

	// Idle once pc_clk has stayed high well past one byte time
	task automatic wait_drained();
		int quiet;
		int t;
		quiet = 0;
		t     = 0;
		while (quiet < 3 * XT_BYTE_CYC && t < 2 * BURST * XT_BYTE_CYC) begin
			@(negedge latch);
			t++;
			quiet = pc_clk ? quiet + 1 : 0;
		end
		if (quiet < 3 * XT_BYTE_CYC) begin
			$display("Timed out waiting for the XT link to go idle");
			other_errors++;
		end
	endtask

	task automatic test_reset();
		check_level("pc_clk", pc_clk, 1'b1);
		check_level("pc_data", pc_data, 1'b1);
		check_status("status", status, '0);
	endtask

	task automatic test_known_codes();
		for (int i = 0; i < 6; i++) begin
			translate_one(known_set2[i], known_set1[i]);
		end
	endtask

	task automatic test_break();
		fork
			begin
				send_ps2(BREAK_PREFIX, PS2_HALF, 1'b0);
				send_ps2(8'h1C, PS2_HALF, 1'b0);
			end
			expect_xt(8'h9E);   // 0x1E with the release bit
		join
		translate_one(8'h1C, 8'h1E);
	endtask

	task automatic test_random_high();
		logic [7:0] code;
		repeat (6) begin
			code = 8'h85 + 8'({$random(seed)} % 107);   // 0x85 up to 0xEF
			translate_one(code, code);
		end
	endtask

	task automatic test_parity();
		xlate_status_t exp_st;
		xlate_status_t seen;
		xlate_status_t seen_next;
		bit            found;
		int            t;
		exp_st.parity_error = 1'b1;
		exp_st.overflow     = 1'b0;
		seen      = '0;
		seen_next = '0;
		found     = 1'b0;
		t         = 0;
		fork
			send_ps2(8'h1C, PS2_HALF, 1'b1);
			while (!found && t < WAIT_LIMIT) begin
				@(negedge latch);
				t++;
				if (status.parity_error) begin
					found = 1'b1;
					seen  = status;
					@(negedge latch);
					seen_next = status;   // Strobe lasts one cycle
				end
			end
		join
		if (found) begin
			check_status("status", seen, exp_st);
			check_status("status after strobe", seen_next, '0);
		end else begin
			$display("No parity error strobe followed a corrupted frame");
			other_errors++;
		end
		expect_quiet(2 * XT_BYTE_CYC);
		translate_one(8'h16, 8'h02);
	endtask

	// Runs last because overflow stays set until reset
	task automatic test_overflow();
		xlate_status_t exp_st;
		exp_st.parity_error = 1'b0;
		exp_st.overflow     = 1'b1;
		fork
			begin
				for (int i = 0; i < BURST; i++) begin
					send_ps2(8'h85 + 8'(i), FAST_HALF, 1'b0);
				end
			end
			begin
				for (int j = 0; j <= FIFO_DEPTH; j++) begin
					expect_xt(8'h85 + 8'(j));   // Nothing lost before the queue fills
				end
			end
		join
		wait_drained();
		check_status("status", status, exp_st);
	endtask

	initial begin
		latch    = 1'b0;
		reset    = 1'b1;
		ps2_clk  = 1'b1;
		ps2_data = 1'b1;
		repeat (3) @(posedge latch);
		@(negedge latch);
		reset = 1'b0;
		test_reset();
		test_known_codes();
		test_break();
		test_random_high();
		test_parity();
		test_overflow();
		$display("Checks finished: %0d value errors, %0d other failures",
			value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

/* kbd_xlate_top.f */
+incdir+hdl
hdl/kbd_pkg.sv
hdl/ps2_rx.sv
hdl/scan_xlate.sv
hdl/scan_fifo.sv
hdl/xt_tx.sv
hdl/kbd_xlate_top.sv
dv/kbd_xlate_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the keyboard bridge simulation with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f kbd_xlate_top.f \
	--top-module kbd_xlate_tb -o kbd_xlate_sim \
	|| { echo "Verilator build failed"; exit 1; }

./obj_dir/kbd_xlate_sim > sim.log 2>&1
cat sim.log

grep -q "^TESTBENCH PASSED$" sim.log && exit 0 || exit 1
